// ==== sim.f ====
hw/rs_pkg.sv
hw/rs_entry_if.sv
hw/rs_pick.sv
hw/rs_entry_array.sv
hw/rs_dispatch.sv
hw/rs_issue.sv
hw/rs_top.sv
tb/rs_checker.sv
tb/rs_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the reservation station testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module rs_tb -f sim.f -o Vrs_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vrs_tb 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "all tests passed"; then
    exit 0
fi
exit 1

// ==== tb/rs_tb.sv ====
// Randomized testbench for the reservation station
// Drives dispatch, CDB, unit readiness and flush from an xorshift stream
// and compares avail_o and is_o with a cycle-level reference model

module rs_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RS_N        = rs_pkg::RS_ENTRY_NUM;
    localparam int DP_N        = rs_pkg::DP_NUM;
    localparam int IS_N        = rs_pkg::IS_NUM;
    localparam int CDB_N       = rs_pkg::CDB_NUM;
    localparam int TAG_W       = rs_pkg::TAG_W;
    localparam int ROB_W       = rs_pkg::ROB_IDX_W;
    localparam int CNT_W       = $clog2(DP_N + 1);
    localparam int RAND_CYCLES = 2000;
    localparam int DRAIN_LIMIT = 400;

    logic                          clk_i;
    logic                          rst_i;
    logic                          flush_i;
    logic [CNT_W-1:0]              dp_num_i;
    rs_pkg::rs_inst_t [DP_N-1:0]   dp_inst_i;
    logic [CNT_W-1:0]              avail_o;
    rs_pkg::cdb_t [CDB_N-1:0]      cdb_i;
    logic [3:0]                    fu_ready_i;
    rs_pkg::rs_issue_t [IS_N-1:0]  is_o;

    // Reference model state
    logic [RS_N-1:0]  m_valid;
    rs_pkg::rs_inst_t m_inst [RS_N];

    logic [31:0] rng_state;
    int          errors;
    int          timeouts;
    int          wait_cnt;
    string       test_name;

    rs_top rs_top_i (.*);

    bind rs_top rs_checker checker_i (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .avail_o (avail_o),
        .is_o    (is_o)
    );

    always #20 clk_i = ~clk_i;

    // ----------------------------------------
    // Random numbers
    // ----------------------------------------
    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Sources come from a pool of 16 tags, mostly already ready
    function automatic rs_pkg::rs_inst_t random_inst();
        rs_pkg::rs_inst_t inst;
        logic [31:0]      r;
        r               = next_rand();
        inst.tag        = r[0 +: TAG_W];
        inst.tag1       = TAG_W'(r[9:6]);
        inst.tag2       = TAG_W'(r[13:10]);
        inst.tag1_ready = r[14] | r[15];
        inst.tag2_ready = r[16] | r[17];
        inst.fu         = rs_pkg::fu_class_e'(r[19:18]);
        inst.rob_idx    = r[20 +: ROB_W];
        return inst;
    endfunction

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    // Lowest ready entries, at most IS_N of them
    function automatic logic [RS_N-1:0] issue_mask(input logic [3:0] fu_rdy);
        logic [RS_N-1:0] sel;
        int              n;
        sel = '0;
        n   = 0;
        for (int e = 0; e < RS_N; e++) begin
            if (m_valid[e] && m_inst[e].tag1_ready && m_inst[e].tag2_ready
                && fu_rdy[m_inst[e].fu] && n < IS_N) begin
                sel[e] = 1'b1;
                n++;
            end
        end
        return sel;
    endfunction

    // Free entries, issuing ones included, capped at the dispatch width
    function automatic logic [CNT_W-1:0] free_count(input logic [3:0] fu_rdy);
        logic [RS_N-1:0] sel;
        int              n;
        sel = issue_mask(fu_rdy);
        n   = 0;
        for (int e = 0; e < RS_N; e++) begin
            if (!m_valid[e] || sel[e]) begin
                n++;
            end
        end
        if (n > DP_N) begin
            n = DP_N;
        end
        return CNT_W'(n);
    endfunction

    task automatic check_outputs();
        logic [RS_N-1:0]   sel;
        rs_pkg::rs_issue_t exp_is [IS_N];
        logic [CNT_W-1:0]  exp_avail;
        int                k;
        sel = issue_mask(fu_ready_i);
        k   = 0;
        for (int c = 0; c < IS_N; c++) begin
            exp_is[c] = '0;
        end
        for (int e = 0; e < RS_N; e++) begin
            if (sel[e]) begin
                exp_is[k].valid   = 1'b1;
                exp_is[k].tag     = m_inst[e].tag;
                exp_is[k].fu      = m_inst[e].fu;
                exp_is[k].rob_idx = m_inst[e].rob_idx;
                k++;
            end
        end
        // Fields matter only on a valid channel
        for (int c = 0; c < IS_N; c++) begin
            if (is_o[c].valid !== exp_is[c].valid
                || (exp_is[c].valid && is_o[c] !== exp_is[c])) begin
                $display("CHECK FAILED %s: is_o[%0d] expected %h actual %h",
                         test_name, c, exp_is[c], is_o[c]);
                errors++;
            end
        end
        exp_avail = free_count(fu_ready_i);
        if (avail_o !== exp_avail) begin
            $display("CHECK FAILED %s: avail_o expected %0d actual %0d",
                     test_name, exp_avail, avail_o);
            errors++;
        end
    endtask

    // Next state for the coming edge: flush, dispatch, issue clear, wake-up
    task automatic advance_model();
        logic [RS_N-1:0] sel;
        int              ch;
        sel = issue_mask(fu_ready_i);
        ch  = 0;
        for (int e = 0; e < RS_N; e++) begin
            if (rst_i || flush_i) begin
                m_valid[e] = 1'b0;
            end else if ((!m_valid[e] || sel[e]) && ch < DP_N && ch < int'(dp_num_i)) begin
                m_valid[e] = 1'b1;
                m_inst[e]  = dp_inst_i[ch];
                ch++;
            end else if (sel[e]) begin
                m_valid[e] = 1'b0;
            end else if (m_valid[e]) begin
                for (int c = 0; c < CDB_N; c++) begin
                    if (cdb_i[c].valid && cdb_i[c].tag == m_inst[e].tag1) begin
                        m_inst[e].tag1_ready = 1'b1;
                    end
                    if (cdb_i[c].valid && cdb_i[c].tag == m_inst[e].tag2) begin
                        m_inst[e].tag2_ready = 1'b1;
                    end
                end
            end
        end
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    // Draining stops dispatch and flush and keeps every unit ready
    task automatic drive_random(input logic draining);
        logic [31:0]                 r;
        logic [3:0]                  fu_rdy;
        logic                        do_flush;
        rs_pkg::cdb_t [CDB_N-1:0]    cdb;
        rs_pkg::rs_inst_t [DP_N-1:0] insts;
        int                          num;
        r        = next_rand();
        fu_rdy   = draining ? 4'hF : (r[3:0] | r[7:4]);
        do_flush = !draining && (r[15:8] == 8'd0);
        for (int c = 0; c < CDB_N; c++) begin
            cdb[c].valid = r[16 + c];
            cdb[c].tag   = TAG_W'(r[20 + 4 * c +: 4]);
        end
        // Sender never exceeds what the station will report
        r   = next_rand();
        num = draining ? 0 : int'(r[7:0]) % (int'(free_count(fu_rdy)) + 1);
        for (int k = 0; k < DP_N; k++) begin
            insts[k] = random_inst();
        end
        fu_ready_i <= fu_rdy;
        flush_i    <= do_flush;
        cdb_i      <= cdb;
        dp_num_i   <= CNT_W'(num);
        dp_inst_i  <= insts;
    endtask

    task automatic run_cycle(input logic draining);
        @(posedge clk_i);
        drive_random(draining);
        @(negedge clk_i);
        check_outputs();
        advance_model();
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        rng_state  = 32'd76;
        errors     = 0;
        timeouts   = 0;
        m_valid    = '0;
        for (int e = 0; e < RS_N; e++) begin
            m_inst[e] = '0;
        end
        clk_i      = 1'b0;
        rst_i      = 1'b1;
        flush_i    = 1'b0;
        dp_num_i   = '0;
        dp_inst_i  = '0;
        cdb_i      = '0;
        fu_ready_i = 4'hF;

        repeat (3) @(posedge clk_i);
        rst_i <= 1'b0;

        // Idle inputs, station must look empty
        test_name = "after reset";
        @(negedge clk_i);
        check_outputs();
        advance_model();

        test_name = "random";
        for (int cyc = 0; cyc < RAND_CYCLES; cyc++) begin
            run_cycle(1'b0);
        end

        // CDB keeps broadcasting until every entry has woken and left
        test_name = "drain";
        wait_cnt  = 0;
        while (m_valid != '0 && wait_cnt < DRAIN_LIMIT) begin
            run_cycle(1'b1);
            wait_cnt++;
        end
        if (m_valid != '0) begin
            $display("Timeout: station did not drain within %0d cycles", DRAIN_LIMIT);
            timeouts++;
        end
        run_cycle(1'b1);

        $display("Errors: %0d check failures, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== tb/rs_checker.sv ====
// Concurrent assertions on the reservation station top-level ports
// Attached to rs_top with bind from the testbench

module rs_checker #(
    parameter int  DP_NUM = rs_pkg::DP_NUM,
    parameter int  IS_NUM = rs_pkg::IS_NUM,
    localparam int CNT_W  = $clog2(DP_NUM + 1)
) (
    input logic                           clk_i,
    input logic                           rst_i,
    input logic [CNT_W-1:0]               avail_o,
    input rs_pkg::rs_issue_t [IS_NUM-1:0] is_o
);
    timeunit 1ns;
    timeprecision 100ps;

    // Valid bits of the issue channels
    logic [IS_NUM-1:0] is_valid;

    always_comb begin
        for (int k = 0; k < IS_NUM; k++) begin
            is_valid[k] = is_o[k].valid;
        end
    end

    // ----------------------------------------
    // Port properties
    // ----------------------------------------
    // Station is empty right after reset
    a_idle_after_reset: assert property (@(posedge clk_i) rst_i |=> (is_valid == '0))
        else $error("issue channel valid in the cycle after reset");

    // Valid channels fill from channel 0 upward
    a_packed: assert property (@(posedge clk_i) disable iff (rst_i)
        !is_valid[0] |-> !is_valid[1])
        else $error("issue channel 1 valid while channel 0 is idle");

    a_avail_max: assert property (@(posedge clk_i) disable iff (rst_i)
        avail_o <= CNT_W'(DP_NUM))
        else $error("avail_o above the dispatch width");

endmodule

// ==== hw/rs_top.sv ====
// Reservation station top level for a single-thread out-of-order core
// Plain ports outside, the three blocks share one rs_entry_if inside
// Counts are set here and passed down to every block

module rs_top #(
    parameter int  ENTRY_NUM = rs_pkg::RS_ENTRY_NUM,
    parameter int  DP_NUM    = rs_pkg::DP_NUM,
    parameter int  IS_NUM    = rs_pkg::IS_NUM,
    parameter int  CDB_NUM   = rs_pkg::CDB_NUM,
    localparam int CNT_W     = $clog2(DP_NUM + 1)
) (
    input  logic                            clk_i,
    input  logic                            rst_i,
    // Branch mispredict or exception, empties the station
    input  logic                            flush_i,
    input  logic [CNT_W-1:0]                dp_num_i,
    input  rs_pkg::rs_inst_t [DP_NUM-1:0]   dp_inst_i,
    output logic [CNT_W-1:0]                avail_o,
    input  rs_pkg::cdb_t [CDB_NUM-1:0]      cdb_i,
    // One level per fu_class_e value
    input  logic [3:0]                      fu_ready_i,
    output rs_pkg::rs_issue_t [IS_NUM-1:0]  is_o
);

    rs_entry_if #(.ENTRY_NUM(ENTRY_NUM)) ent_if ();

    rs_entry_array #(
        .ENTRY_NUM (ENTRY_NUM),
        .CDB_NUM   (CDB_NUM)
    ) entry_array (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .flush_i    (flush_i),
        .cdb_i      (cdb_i),
        .fu_ready_i (fu_ready_i),
        .ent        (ent_if.array)
    );

    rs_dispatch #(
        .ENTRY_NUM (ENTRY_NUM),
        .DP_NUM    (DP_NUM)
    ) dispatch (
        .dp_num_i  (dp_num_i),
        .dp_inst_i (dp_inst_i),
        .avail_o   (avail_o),
        .ent       (ent_if.dispatch)
    );

    rs_issue #(
        .ENTRY_NUM (ENTRY_NUM),
        .IS_NUM    (IS_NUM)
    ) issue (
        .is_o (is_o),
        .ent  (ent_if.issue)
    );

endmodule

// ==== hw/rs_issue.sv ====
// Issue side of the reservation station
// Picks up to IS_NUM ready entries, lowest index first, and drives them
// onto the issue channels packed from channel 0 upward

module rs_issue #(
    parameter int  ENTRY_NUM = rs_pkg::RS_ENTRY_NUM,
    parameter int  IS_NUM    = rs_pkg::IS_NUM,
    localparam int IDX_W     = (ENTRY_NUM > 1) ? $clog2(ENTRY_NUM) : 1
) (
    output rs_pkg::rs_issue_t [IS_NUM-1:0]  is_o,
    rs_entry_if.issue                       ent
);

    logic [IS_NUM-1:0][IDX_W-1:0] pick_idx;
    logic [IS_NUM-1:0]            pick_found;

    // ----------------------------------------
    // Selection
    // ----------------------------------------
    rs_pick #(
        .ENTRY_NUM (ENTRY_NUM),
        .PICK_NUM  (IS_NUM)
    ) ready_pick (
        .mask_i  (ent.ready),
        .idx_o   (pick_idx),
        .found_o (pick_found)
    );

    // ----------------------------------------
    // Issue switch
    // ----------------------------------------
    // Found bits fill from stage 0, so valid channels stay packed
    always_comb begin
        ent.is_sel = '0;
        is_o       = '0;
        for (int k = 0; k < IS_NUM; k++) begin
            if (pick_found[k]) begin
                // Entry is freed at the next edge
                ent.is_sel[pick_idx[k]] = 1'b1;
                is_o[k].valid           = 1'b1;
                is_o[k].tag             = ent.entries[pick_idx[k]].inst.tag;
                is_o[k].fu              = ent.entries[pick_idx[k]].inst.fu;
                is_o[k].rob_idx         = ent.entries[pick_idx[k]].inst.rob_idx;
            end
        end
    end

endmodule

// ==== hw/rs_dispatch.sv ====
// Dispatch side of the reservation station
// Places incoming instructions into the lowest free entries and reports
// how many entries the sender may fill in this cycle

module rs_dispatch #(
    parameter int  ENTRY_NUM = rs_pkg::RS_ENTRY_NUM,
    parameter int  DP_NUM    = rs_pkg::DP_NUM,
    localparam int IDX_W     = (ENTRY_NUM > 1) ? $clog2(ENTRY_NUM) : 1,
    localparam int CNT_W     = $clog2(DP_NUM + 1)
) (
    input  logic [CNT_W-1:0]                  dp_num_i,
    input  rs_pkg::rs_inst_t [DP_NUM-1:0]     dp_inst_i,
    output logic [CNT_W-1:0]                  avail_o,
    rs_entry_if.dispatch                      ent
);

    logic [ENTRY_NUM-1:0]          free_mask;
    logic [DP_NUM-1:0][IDX_W-1:0]  pick_idx;
    logic [DP_NUM-1:0]             pick_found;
    logic [DP_NUM-1:0]             dp_valid;

    // Entries leaving through issue this cycle count as free
    always_comb begin
        for (int e = 0; e < ENTRY_NUM; e++) begin
            free_mask[e] = !ent.entries[e].valid || ent.is_sel[e];
        end
    end

    rs_pick #(
        .ENTRY_NUM (ENTRY_NUM),
        .PICK_NUM  (DP_NUM)
    ) free_pick (
        .mask_i  (free_mask),
        .idx_o   (pick_idx),
        .found_o (pick_found)
    );

    // Channel k carries an instruction only when k < dp_num_i
    always_comb begin
        for (int k = 0; k < DP_NUM; k++) begin
            dp_valid[k] = pick_found[k] && (CNT_W'(k) < dp_num_i);
        end
    end

    // Route each live channel to its chosen entry
    always_comb begin
        ent.dp_sel  = '0;
        ent.dp_data = '0;
        for (int e = 0; e < ENTRY_NUM; e++) begin
            for (int k = 0; k < DP_NUM; k++) begin
                if (dp_valid[k] && (pick_idx[k] == IDX_W'(e))) begin
                    ent.dp_sel[e]  = 1'b1;
                    ent.dp_data[e] = dp_inst_i[k];
                end
            end
        end
    end

    // Found outputs equal the free count already capped at DP_NUM
    always_comb begin
        avail_o = '0;
        for (int k = 0; k < DP_NUM; k++) begin
            avail_o = avail_o + CNT_W'(pick_found[k]);
        end
    end

endmodule

// ==== hw/rs_entry_array.sv ====
// Reservation station entry storage
// Applies flush, dispatch write, issue clear and CDB wake-up at each edge,
// in that priority, and reports which entries are ready to issue

module rs_entry_array #(
    parameter int ENTRY_NUM = rs_pkg::RS_ENTRY_NUM,
    parameter int CDB_NUM   = rs_pkg::CDB_NUM
) (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic                            flush_i,
    input  rs_pkg::cdb_t [CDB_NUM-1:0]      cdb_i,
    input  logic [3:0]                      fu_ready_i,
    rs_entry_if.array                       ent
);

    rs_pkg::rs_entry_t [ENTRY_NUM-1:0] entry_q;

    // Per-entry source tag hits on the CDB
    logic [ENTRY_NUM-1:0] wake1;
    logic [ENTRY_NUM-1:0] wake2;

    // ----------------------------------------
    // CDB comparator networks
    // ----------------------------------------
    // Source 1
    always_comb begin
        wake1 = '0;
        for (int e = 0; e < ENTRY_NUM; e++) begin
            for (int c = 0; c < CDB_NUM; c++) begin
                if (cdb_i[c].valid && (cdb_i[c].tag == entry_q[e].inst.tag1)) begin
                    wake1[e] = 1'b1;
                end
            end
        end
    end

    // Source 2, independent of source 1
    always_comb begin
        wake2 = '0;
        for (int e = 0; e < ENTRY_NUM; e++) begin
            for (int c = 0; c < CDB_NUM; c++) begin
                if (cdb_i[c].valid && (cdb_i[c].tag == entry_q[e].inst.tag2)) begin
                    wake2[e] = 1'b1;
                end
            end
        end
    end

    // ----------------------------------------
    // Entry registers
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        for (int e = 0; e < ENTRY_NUM; e++) begin
            if (rst_i || flush_i) begin
                entry_q[e].valid <= 1'b0;
            end else if (ent.dp_sel[e]) begin
                // New instruction, ignores this cycle's CDB
                entry_q[e].valid <= 1'b1;
                entry_q[e].inst  <= ent.dp_data[e];
            end else if (ent.is_sel[e]) begin
                entry_q[e].valid <= 1'b0;
            end else if (entry_q[e].valid) begin
                // Each source wakes on its own
                if (wake1[e]) begin
                    entry_q[e].inst.tag1_ready <= 1'b1;
                end
                if (wake2[e]) begin
                    entry_q[e].inst.tag2_ready <= 1'b1;
                end
            end
        end
    end

    assign ent.entries = entry_q;

    // ----------------------------------------
    // Readiness
    // ----------------------------------------
    // Valid, both sources present and the unit class accepting work
    always_comb begin
        for (int e = 0; e < ENTRY_NUM; e++) begin
            ent.ready[e] = entry_q[e].valid
                         && entry_q[e].inst.tag1_ready
                         && entry_q[e].inst.tag2_ready
                         && fu_ready_i[entry_q[e].inst.fu];
        end
    end

endmodule

// ==== hw/rs_pick.sv ====
// Multi-output priority encoder
// Returns the indices of the first PICK_NUM set bits of mask_i, lowest first
// Used for both free-entry allocation and ready-entry issue

module rs_pick #(
    parameter int  ENTRY_NUM = rs_pkg::RS_ENTRY_NUM,
    parameter int  PICK_NUM  = 2,
    localparam int IDX_W     = (ENTRY_NUM > 1) ? $clog2(ENTRY_NUM) : 1
) (
    input  logic [ENTRY_NUM-1:0]            mask_i,
    output logic [PICK_NUM-1:0][IDX_W-1:0]  idx_o,
    output logic [PICK_NUM-1:0]             found_o
);

    // Remaining candidates seen by each stage
    logic [ENTRY_NUM-1:0] stage_bits [PICK_NUM];

    assign stage_bits[0] = mask_i;

    for (genvar k = 0; k < PICK_NUM; k++) begin : g_stage
        logic [IDX_W-1:0]     idx;
        logic                 hit;
        logic [ENTRY_NUM-1:0] pick_1h;

        // Lowest set bit of what the earlier stages left
        always_comb begin
            idx     = '0;
            hit     = 1'b0;
            pick_1h = '0;
            for (int i = 0; i < ENTRY_NUM; i++) begin
                if (stage_bits[k][i] && !hit) begin
                    idx        = IDX_W'(i);
                    hit        = 1'b1;
                    pick_1h[i] = 1'b1;
                end
            end
        end

        assign idx_o[k]   = idx;
        assign found_o[k] = hit;

        // Hide this stage's choice from the next one
        if (k < PICK_NUM - 1) begin : g_chain
            assign stage_bits[k+1] = stage_bits[k] & ~pick_1h;
        end
    end

endmodule

// ==== hw/rs_entry_if.sv ====
// Per-entry signals shared by the entry array, dispatch and issue logic
// The array owns the state, dispatch and issue send back one-hot selects
// All vectors are indexed by entry number

interface rs_entry_if #(
    parameter int ENTRY_NUM = rs_pkg::RS_ENTRY_NUM
);

    // Stored state of every entry
    rs_pkg::rs_entry_t [ENTRY_NUM-1:0] entries;
    // Entry can issue this cycle
    logic [ENTRY_NUM-1:0]              ready;
    // Dispatch write enable and the instruction routed to each entry
    logic [ENTRY_NUM-1:0]              dp_sel;
    rs_pkg::rs_inst_t [ENTRY_NUM-1:0]  dp_data;
    // Entry leaves on an issue channel this cycle
    logic [ENTRY_NUM-1:0]              is_sel;

    // Storage side
    modport array (
        output entries, ready,
        input  dp_sel, dp_data, is_sel
    );

    // Dispatch routing, needs is_sel to reuse entries freed this cycle
    modport dispatch (
        input  entries, is_sel,
        output dp_sel, dp_data
    );

    // Issue selection
    modport issue (
        input  entries, ready,
        output is_sel
    );

endinterface

// ==== hw/rs_pkg.sv ====
// Shared sizes and types for the reservation station
// Every design file refers to these by scoped names, never by import
// The module parameters of rs_top take their defaults from here

package rs_pkg;

    // ----------------------------------------
    // Sizes
    // ----------------------------------------
    localparam int RS_ENTRY_NUM = 8;
    localparam int DP_NUM       = 2;
    localparam int IS_NUM       = 2;
    localparam int CDB_NUM      = 2;
    // Physical register tag and reorder buffer index widths
    localparam int TAG_W        = 6;
    localparam int ROB_IDX_W    = 5;

    // ----------------------------------------
    // Types
    // ----------------------------------------
    // Functional unit class, also the bit position in fu_ready_i
    typedef enum logic [1:0] {
        FU_ALU  = 2'd0,
        FU_MULT = 2'd1,
        FU_MEM  = 2'd2,
        FU_BR   = 2'd3
    } fu_class_e;

    // Decoded instruction as it arrives from dispatch
    typedef struct packed {
        logic [TAG_W-1:0]     tag;
        logic [TAG_W-1:0]     tag1;
        logic [TAG_W-1:0]     tag2;
        logic                 tag1_ready;
        logic                 tag2_ready;
        fu_class_e            fu;
        logic [ROB_IDX_W-1:0] rob_idx;
    } rs_inst_t;

    // One stored slot
    typedef struct packed {
        logic     valid;
        rs_inst_t inst;
    } rs_entry_t;

    // Completion broadcast, one tag per channel
    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
    } cdb_t;

    // What leaves on an issue channel
    typedef struct packed {
        logic                 valid;
        logic [TAG_W-1:0]     tag;
        fu_class_e            fu;
        logic [ROB_IDX_W-1:0] rob_idx;
    } rs_issue_t;

endpackage
